// File: common/ninjin_pkg.sv
package ninjin_pkg;

  // ========================================
  // bus widths
  // ========================================
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 12;
  localparam int ID_WIDTH   = 12;
  localparam int LSB        = $clog2(DATA_WIDTH / 8);

  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [DATA_WIDTH/8-1:0] strb_t;
  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [ADDR_WIDTH-LSB-1:0] word_addr_t;
  typedef logic [ID_WIDTH-1:0]     axi_id_t;
  typedef logic [7:0]              len_t;
  typedef logic [2:0]              size_t;
  typedef logic [1:0]              burst_t;
  typedef logic [1:0]              resp_t;

  // burst and response codes
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;
  localparam size_t  SIZE_WORD   = 3'd2;
  localparam resp_t  RESP_OKAY   = 2'b00;

  // ========================================
  // channel payloads
  // ========================================
  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
    len_t    len;
    size_t   size;
    burst_t  burst;
  } axi_ax_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t id;
    resp_t   resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } axi_r_t;

  // single-port memory request
  typedef struct packed {
    logic       en;
    logic       we;
    strb_t      be;
    word_addr_t addr;
    data_t      wdata;
  } mem_req_t;

endpackage

// File: rtl/s_axi/axi_burst_addr_gen.sv
`timescale 1ns/1ns

module axi_burst_addr_gen
  ( input  logic                   clk
  , input  logic                   xrst
  , input  logic                   load
  , input  ninjin_pkg::axi_ax_t    ax
  , input  logic                   advance
  , output ninjin_pkg::word_addr_t word_addr
  , output logic                   beat_last
  );

  import ninjin_pkg::*;

  burst_t     burst_q;
  len_t       len_q;
  len_t       cnt;
  len_t       cnt_next;
  word_addr_t wrap_mask;
  word_addr_t incr_addr;
  word_addr_t next_addr;

  // wrap block is len+1 words, so len itself is the mask
  always_comb begin
    wrap_mask = word_addr_t'(len_q[3:0]);
    incr_addr = word_addr + word_addr_t'(1);
    cnt_next  = cnt + len_t'(1);
    case (burst_q)
      BURST_FIXED: next_addr = word_addr;
      BURST_INCR:  next_addr = incr_addr;
      BURST_WRAP:  next_addr = (word_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default:     next_addr = incr_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      word_addr <= '0;
      burst_q   <= BURST_INCR;
      len_q     <= '0;
      cnt       <= '0;
      beat_last <= 1'b0;
    end else if (load) begin
      word_addr <= ax.addr[ADDR_WIDTH-1:LSB];
      burst_q   <= ax.burst;
      len_q     <= ax.len;
      cnt       <= '0;
      beat_last <= (ax.len == '0);
    end else if (advance) begin
      word_addr <= next_addr;
      cnt       <= cnt_next;
      beat_last <= (cnt_next == len_q);
    end
  end

  a_size_word: assert property (
    @(posedge clk) disable iff (!xrst)
    load |-> (ax.size == SIZE_WORD)
  );

  a_wrap_len: assert property (
    @(posedge clk) disable iff (!xrst)
    load && ax.burst == BURST_WRAP |-> ax.len inside {8'd1, 8'd3, 8'd7, 8'd15}
  );

  a_wrap_align: assert property (
    @(posedge clk) disable iff (!xrst)
    load && ax.burst == BURST_WRAP |-> (ax.addr[LSB-1:0] == '0)
  );

endmodule

// File: rtl/s_axi/ninjin_s_axi_renkon.sv
`timescale 1ns/1ns

module ninjin_s_axi_renkon
  ( input  logic                clk
  , input  logic                xrst
  , input  ninjin_pkg::axi_ax_t aw
  , input  logic                awvalid
  , output logic                awready
  , input  ninjin_pkg::axi_w_t  w
  , input  logic                wvalid
  , output logic                wready
  , output ninjin_pkg::axi_b_t  b
  , output logic                bvalid
  , input  logic                bready
  , input  ninjin_pkg::axi_ax_t ar
  , input  logic                arvalid
  , output logic                arready
  , output ninjin_pkg::axi_r_t  r
  , output logic                rvalid
  , input  logic                rready
  , output ninjin_pkg::mem_req_t mem_req
  , input  ninjin_pkg::data_t   mem_rdata
  );

  import ninjin_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WDATA,
    ST_BRESP,
    ST_RFETCH,
    ST_RDATA
  } state_t;

  state_t     state;
  logic       aw_hs;
  logic       w_hs;
  logic       b_hs;
  logic       ar_hs;
  logic       r_hs;
  axi_id_t    id_q;
  logic       gen_load;
  logic       gen_advance;
  axi_ax_t    gen_ax;
  word_addr_t word_addr;
  logic       beat_last;
  logic       rd_held;
  data_t      rdata_q;

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;
  assign b_hs  = bvalid && bready;
  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;

  // ========================================
  // transaction fsm
  // ========================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= ST_IDLE;
      awready <= 1'b0;
      arready <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // write wins when both address channels are waiting
          if (aw_hs) begin
            awready <= 1'b0;
            state   <= ST_WDATA;
          end else if (ar_hs) begin
            arready <= 1'b0;
            state   <= ST_RFETCH;
          end else if (awvalid && !awready && !arready) begin
            awready <= 1'b1;
          end else if (arvalid && !arready && !awready) begin
            arready <= 1'b1;
          end
        end
        ST_WDATA: begin
          if (w_hs && w.last) begin
            state <= ST_BRESP;
          end
        end
        ST_BRESP: begin
          if (b_hs) begin
            state <= ST_IDLE;
          end
        end
        ST_RFETCH: begin
          state <= ST_RDATA;
        end
        ST_RDATA: begin
          if (r_hs) begin
            state <= beat_last ? ST_IDLE : ST_RFETCH;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // id of the accepted burst
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q <= aw.id;
    end else if (ar_hs) begin
      id_q <= ar.id;
    end
  end

  // ========================================
  // burst address generator
  // ========================================
  assign gen_load    = aw_hs || ar_hs;
  assign gen_ax      = aw_hs ? aw : ar;
  assign gen_advance = w_hs || r_hs;

  axi_burst_addr_gen axi_burst_addr_gen_inst
    ( .clk       (clk)
    , .xrst      (xrst)
    , .load      (gen_load)
    , .ax        (gen_ax)
    , .advance   (gen_advance)
    , .word_addr (word_addr)
    , .beat_last (beat_last)
    );

  // ========================================
  // channel outputs
  // ========================================
  assign wready = (state == ST_WDATA);
  assign bvalid = (state == ST_BRESP);
  assign rvalid = (state == ST_RDATA);

  assign b.id   = id_q;
  assign b.resp = RESP_OKAY;

  // read data capture under back-pressure
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rd_held <= 1'b0;
    end else begin
      rd_held <= rvalid && !rready;
    end
  end

  always_ff @(posedge clk) begin
    if (rvalid && !rready) begin
      rdata_q <= r.data;
    end
  end

  assign r.id   = id_q;
  assign r.data = rd_held ? rdata_q : mem_rdata;
  assign r.resp = RESP_OKAY;
  assign r.last = beat_last;

  // write beats and read fetches share the one memory port
  always_comb begin
    mem_req.en    = w_hs || (state == ST_RFETCH);
    mem_req.we    = (state == ST_WDATA);
    mem_req.be    = w.strb;
    mem_req.addr  = word_addr;
    mem_req.wdata = w.data;
  end

  // ========================================
  // assertions
  // ========================================
  a_wlast_match: assert property (
    @(posedge clk) disable iff (!xrst)
    w_hs |-> (w.last == beat_last)
  );

  a_b_hold: assert property (
    @(posedge clk) disable iff (!xrst)
    bvalid && !bready |=> bvalid && $stable(b)
  );

  a_r_hold: assert property (
    @(posedge clk) disable iff (!xrst)
    rvalid && !rready |=> rvalid && $stable(r)
  );

endmodule

// File: rtl/renkon_mem.sv
`timescale 1ns/1ns

module renkon_mem
  #( parameter int MEM_AW = 10
   )
  ( input  logic                 clk
  , input  logic                 xrst
  , input  ninjin_pkg::mem_req_t req
  , output ninjin_pkg::data_t    rdata
  );

  import ninjin_pkg::*;

  data_t             mem [2**MEM_AW];
  logic [MEM_AW-1:0] idx;

  assign idx = req.addr[MEM_AW-1:0];

  // byte merge under be
  always_ff @(posedge clk) begin
    if (req.en && req.we) begin
      for (int i = 0; i < DATA_WIDTH / 8; i++) begin
        if (req.be[i]) begin
          mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rdata <= '0;
    end else if (req.en && !req.we) begin
      rdata <= mem[idx];
    end
  end

endmodule

// File: rtl/ninjin_renkon_top.sv
`timescale 1ns/1ns

module ninjin_renkon_top
  #( parameter int MEM_AW = 10
   )
  ( input  logic                clk
  , input  logic                xrst
  , input  ninjin_pkg::axi_ax_t aw
  , input  logic                awvalid
  , output logic                awready
  , input  ninjin_pkg::axi_w_t  w
  , input  logic                wvalid
  , output logic                wready
  , output ninjin_pkg::axi_b_t  b
  , output logic                bvalid
  , input  logic                bready
  , input  ninjin_pkg::axi_ax_t ar
  , input  logic                arvalid
  , output logic                arready
  , output ninjin_pkg::axi_r_t  r
  , output logic                rvalid
  , input  logic                rready
  );

  import ninjin_pkg::*;

  mem_req_t mem_req;
  data_t    mem_rdata;

  // ========================================
  // axi slave
  // ========================================
  ninjin_s_axi_renkon ninjin_s_axi_renkon_inst
    ( .clk       (clk)
    , .xrst      (xrst)
    , .aw        (aw)
    , .awvalid   (awvalid)
    , .awready   (awready)
    , .w         (w)
    , .wvalid    (wvalid)
    , .wready    (wready)
    , .b         (b)
    , .bvalid    (bvalid)
    , .bready    (bready)
    , .ar        (ar)
    , .arvalid   (arvalid)
    , .arready   (arready)
    , .r         (r)
    , .rvalid    (rvalid)
    , .rready    (rready)
    , .mem_req   (mem_req)
    , .mem_rdata (mem_rdata)
    );

  // word ram
  renkon_mem #(
    .MEM_AW (MEM_AW)
  ) renkon_mem_inst
    ( .clk   (clk)
    , .xrst  (xrst)
    , .req   (mem_req)
    , .rdata (mem_rdata)
    );

endmodule

// File: verification/renkon_axi_tasks.svh
task automatic check_equal(input logic [63:0] expected, input logic [63:0] actual,
                           input string what);
  if (expected !== actual) begin
    $display("Mismatch at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
    $display("Simulation failed");
    $fatal(1, "stopping at first mismatch");
  end
endtask

// ========================================
// write burst of aw, w beats and b
// ========================================
task automatic write_burst(input axi_id_t id, input word_addr_t start, input len_t len,
                           input burst_t burst);
  word_addr_t cur;
  axi_b_t     held;
  cur = start;
  @(negedge clk);
  repeat (random_gap()) @(negedge clk);
  aw.id    = id;
  aw.addr  = {start, 2'b00};
  aw.len   = len;
  aw.size  = SIZE_WORD;
  aw.burst = burst;
  awvalid  = 1'b1;
  while (!awready) @(negedge clk);
  @(negedge clk);
  awvalid = 1'b0;
  for (int i = 0; i <= int'(len); i++) begin
    repeat (random_gap()) @(negedge clk);
    w.data = beat_data[8'(i)];
    w.strb = beat_strb[8'(i)];
    w.last = (i == int'(len));
    wvalid = 1'b1;
    while (!wready) @(negedge clk);
    model_mem[cur] = merge_bytes(model_mem[cur], beat_data[8'(i)], beat_strb[8'(i)]);
    cur = next_word(cur, start, len, burst);
    @(negedge clk);
    wvalid = 1'b0;
  end
  while (!bvalid) @(negedge clk);
  held = b;
  // hold bready low for a while
  repeat (random_gap()) begin
    @(negedge clk);
    check_equal(64'(1'b1), 64'(bvalid), "bvalid dropped under back-pressure");
    check_equal(64'(held), 64'(b), "b payload changed under back-pressure");
  end
  bready = 1'b1;
  check_equal(64'(id), 64'(b.id), "bid");
  check_equal(64'(RESP_OKAY), 64'(b.resp), "bresp");
  b_done_time = $time;
  @(negedge clk);
  bready = 1'b0;
endtask

// ========================================
// read burst of ar and r beats
// ========================================
task automatic read_burst(input axi_id_t id, input word_addr_t start, input len_t len,
                          input burst_t burst);
  word_addr_t cur;
  axi_r_t     held;
  cur = start;
  @(negedge clk);
  repeat (random_gap()) @(negedge clk);
  ar.id    = id;
  ar.addr  = {start, 2'b00};
  ar.len   = len;
  ar.size  = SIZE_WORD;
  ar.burst = burst;
  arvalid  = 1'b1;
  while (!arready) @(negedge clk);
  ar_accept_time = $time;
  @(negedge clk);
  arvalid = 1'b0;
  for (int i = 0; i <= int'(len); i++) begin
    while (!rvalid) @(negedge clk);
    held = r;
    repeat (random_gap()) begin
      @(negedge clk);
      check_equal(64'(1'b1), 64'(rvalid), "rvalid dropped under back-pressure");
      check_equal(64'(held), 64'(r), "r payload changed under back-pressure");
    end
    rready = 1'b1;
    check_equal(64'(model_mem[cur]), 64'(r.data), $sformatf("rdata beat %0d", i));
    check_equal(64'(id), 64'(r.id), "rid");
    check_equal(64'(RESP_OKAY), 64'(r.resp), "rresp");
    check_equal(64'(i == int'(len)), 64'(r.last), $sformatf("rlast beat %0d", i));
    cur = next_word(cur, start, len, burst);
    @(negedge clk);
    rready = 1'b0;
  end
endtask

// File: verification/tb_renkon_top.sv
`timescale 1ns/1ns

module tb_renkon_top;

  import ninjin_pkg::*;

  localparam int MEM_AW          = 10;
  localparam int DEPTH           = 2**MEM_AW;
  localparam int FILL_BURSTS     = DEPTH / 16;
  localparam int N_RANDOM        = 12;
  // five random phases with a write and a read per iteration
  localparam int N_BURSTS        = FILL_BURSTS + 2 * 5 * N_RANDOM;
  localparam int WATCHDOG_CYCLES = N_BURSTS * 40 + 1000;

  logic    clk;
  logic    xrst;
  axi_ax_t aw;
  logic    awvalid;
  logic    awready;
  axi_w_t  w;
  logic    wvalid;
  logic    wready;
  axi_b_t  b;
  logic    bvalid;
  logic    bready;
  axi_ax_t ar;
  logic    arvalid;
  logic    arready;
  axi_r_t  r;
  logic    rvalid;
  logic    rready;

  integer  seed;
  int      max_gap;
  data_t   model_mem [DEPTH];
  data_t   beat_data [256];
  strb_t   beat_strb [256];
  time     b_done_time;
  time     ar_accept_time;

  ninjin_renkon_top #(
    .MEM_AW (MEM_AW)
  ) ninjin_renkon_top_inst
    ( .clk (clk), .xrst (xrst)
    , .aw (aw), .awvalid (awvalid), .awready (awready)
    , .w (w), .wvalid (wvalid), .wready (wready)
    , .b (b), .bvalid (bvalid), .bready (bready)
    , .ar (ar), .arvalid (arvalid), .arready (arready)
    , .r (r), .rvalid (rvalid), .rready (rready)
    );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: test sequence still running after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  // ========================================
  // reference model
  // ========================================
  function automatic int random_gap();
    return int'($unsigned($random(seed)) % (max_gap + 1));
  endfunction

  function automatic word_addr_t next_word(input word_addr_t cur, input word_addr_t start,
                                           input len_t len, input burst_t burst);
    int         blk;
    word_addr_t base;
    blk  = int'(len) + 1;
    base = start - word_addr_t'(int'(start) % blk);
    case (burst)
      BURST_FIXED: return cur;
      // stay inside the aligned block of len+1 words
      BURST_WRAP:  return base + word_addr_t'((int'(cur - base) + 1) % blk);
      default:     return cur + word_addr_t'(1);
    endcase
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
    data_t res;
    res = old;
    for (int k = 0; k < DATA_WIDTH / 8; k++) begin
      if (strb[k]) begin
        res[8*k +: 8] = data[8*k +: 8];
      end
    end
    return res;
  endfunction

  `include "renkon_axi_tasks.svh"

  task automatic fill_beats(input len_t len, input bit rand_strb);
    for (int i = 0; i <= int'(len); i++) begin
      beat_data[8'(i)] = $random(seed);
      beat_strb[8'(i)] = rand_strb ? strb_t'($random(seed)) : 4'hf;
    end
  endtask

  task automatic round_trip(input burst_t burst, input len_t len, input word_addr_t start,
                            input bit rand_strb);
    fill_beats(len, rand_strb);
    write_burst(axi_id_t'($random(seed)), start, len, burst);
    read_burst(axi_id_t'($random(seed)), start, len, burst);
  endtask

  task automatic check_idle_outputs(input string phase);
    check_equal(64'(0), 64'({awready, wready, bvalid, arready, rvalid}),
                {"channel outputs ", phase});
    check_equal(64'(0), 64'(ninjin_renkon_top_inst.mem_req.en), {"memory enable ", phase});
  endtask

  // ========================================
  // test sequence
  // ========================================
  initial begin
    len_t       len;
    word_addr_t start;
    axi_id_t    wid;
    axi_id_t    rid;
    seed           = 9;
    max_gap        = 0;
    xrst           = 1'b0;
    aw             = '0;
    awvalid        = 1'b0;
    w              = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    ar             = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    b_done_time    = 0;
    ar_accept_time = 0;
    repeat (2) begin
      @(negedge clk);
      check_idle_outputs("during reset");
    end
    xrst = 1'b1;
    @(negedge clk);
    check_idle_outputs("after reset");
    // whole memory written before any read
    for (int k = 0; k < FILL_BURSTS; k++) begin
      fill_beats(8'd15, 1'b0);
      write_burst(axi_id_t'(k), word_addr_t'(16 * k), 8'd15, BURST_INCR);
    end
    max_gap = 2;
    for (int k = 0; k < N_RANDOM; k++) begin
      len   = len_t'($unsigned($random(seed)) % 16);
      start = word_addr_t'($unsigned($random(seed)) % (DEPTH - int'(len)));
      round_trip(BURST_INCR, len, start, 1'b0);
    end
    // wrap from an unaligned word
    for (int k = 0; k < N_RANDOM; k++) begin
      len   = len_t'((2 << ($unsigned($random(seed)) % 4)) - 1);
      start = word_addr_t'($random(seed));
      if ((int'(start) % (int'(len) + 1)) == 0) begin
        start = start + word_addr_t'(1);
      end
      round_trip(BURST_WRAP, len, start, 1'b0);
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      len   = len_t'(1 + $unsigned($random(seed)) % 7);
      start = word_addr_t'($random(seed));
      round_trip(BURST_FIXED, len, start, 1'b0);
    end
    // byte strobes
    for (int k = 0; k < N_RANDOM; k++) begin
      len   = len_t'($unsigned($random(seed)) % 16);
      start = word_addr_t'($unsigned($random(seed)) % (DEPTH - int'(len)));
      round_trip(BURST_INCR, len, start, 1'b1);
    end
    // aw and ar raised on the same edge so the write goes first
    max_gap = 0;
    for (int k = 0; k < N_RANDOM; k++) begin
      len   = len_t'($unsigned($random(seed)) % 16);
      start = word_addr_t'($unsigned($random(seed)) % (DEPTH - int'(len)));
      wid   = axi_id_t'($random(seed));
      rid   = axi_id_t'($random(seed));
      fill_beats(len, 1'b1);
      fork
        write_burst(wid, start, len, BURST_INCR);
        read_burst(rid, start, len, BURST_INCR);
      join
      check_equal(64'(1'b1), 64'(ar_accept_time > b_done_time),
                  "arready given before the write response");
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: build.f
+incdir+verification
common/ninjin_pkg.sv
rtl/s_axi/axi_burst_addr_gen.sv
rtl/s_axi/ninjin_s_axi_renkon.sv
rtl/renkon_mem.sv
rtl/ninjin_renkon_top.sv
verification/tb_renkon_top.sv

// File: Makefile
# Verilator flow for the renkon memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_renkon_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
